// File: Makefile
TOP := sha256_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f sha256_core.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sha256_core.f

clean:
	rm -rf obj_dir $(LOG)

// File: design/msg_fetch.sv
`timescale 1ns/100ps
`include "sha_params.svh"

module msg_fetch (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,
	input  wb_pkg::wb_adr_t  base,
	output logic             wb_cyc,
	output logic             wb_stb,
	output wb_pkg::wb_adr_t  wb_adr,
	input  wb_pkg::wb_dat_t  wb_rdata,
	input  logic             wb_ack,
	output logic             ld_valid,
	output sha_pkg::sha_word_t ld_word
);
	import wb_pkg::*;

	localparam int CNT_W = $clog2(`SHA_BLOCK_WORDS);
	localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`SHA_BLOCK_WORDS - 1);

	logic             active;
	logic [CNT_W-1:0] cnt;
	logic             xfer;

	// read-only master, cyc and stb move together
	assign wb_cyc = active;
	assign wb_stb = active;

	// a transfer completes on ack while strobing
	assign xfer = active & wb_ack;

	//////////////////////////////////////////////////////////////////////
	// bus cycle control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active   <= 1'b0;
			cnt      <= '0;
			ld_valid <= 1'b0;
		end else begin
			ld_valid <= 1'b0;
			if (start) begin
				active <= 1'b1;
				cnt    <= '0;
			end else if (xfer) begin
				ld_valid <= 1'b1;
				cnt      <= cnt + 1'b1;
				// cycle ends with the last block word
				if (cnt == LAST_WORD) begin
					active <= 1'b0;
				end
			end
		end
	end

	// address steps once per ack, wraps at the top of memory
	always_ff @(posedge clk) begin
		if (start) begin
			wb_adr <= base;
		end else if (xfer) begin
			wb_adr  <= wb_adr + wb_adr_t'(1);
			ld_word <= wb_rdata;
		end
	end

endmodule

// File: design/msg_schedule.sv
`timescale 1ns/100ps
`include "sha_params.svh"

module msg_schedule (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic               ld_valid,
	input  sha_pkg::sha_word_t ld_word,
	output logic               w_valid,
	output sha_pkg::sha_word_t w_word,
	output sha_pkg::sha_round_t w_round,
	output logic               w_last
);
	import sha_pkg::*;

	localparam sha_round_t LAST_LOAD  = sha_round_t'(`SHA_BLOCK_WORDS - 1);
	localparam sha_round_t LAST_ROUND = sha_round_t'(`SHA_ROUNDS - 1);

	// win[0] is the oldest word W[t-16], win[15] the newest W[t-1]
	sha_word_t  win [0:`SHA_BLOCK_WORDS-1];
	sha_round_t rnd;
	logic       gen;
	logic       shift_en;
	sha_word_t  w_gen;
	sha_word_t  w_in;

	function automatic sha_word_t small_sigma0(input sha_word_t x);
		return sha_rotr(x, 7) ^ sha_rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic sha_word_t small_sigma1(input sha_word_t x);
		return sha_rotr(x, 17) ^ sha_rotr(x, 19) ^ (x >> 10);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// expansion from the window
	//////////////////////////////////////////////////////////////////////

	// W[t] from W[t-2], W[t-7], W[t-15] and W[t-16]
	assign w_gen = small_sigma1(win[14]) + win[9] + small_sigma0(win[1]) + win[0];

	assign shift_en = ld_valid | gen;
	assign w_in     = gen ? w_gen : ld_word;

	// round counter and load / expand phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rnd     <= '0;
			gen     <= 1'b0;
			w_valid <= 1'b0;
			w_last  <= 1'b0;
		end else if (start) begin
			rnd     <= '0;
			gen     <= 1'b0;
			w_valid <= 1'b0;
			w_last  <= 1'b0;
		end else begin
			w_valid <= shift_en;
			w_last  <= shift_en && (rnd == LAST_ROUND);
			if (shift_en) begin
				rnd <= rnd + 1'b1;
			end
			// window is full once word 15 has loaded
			if (ld_valid && rnd == LAST_LOAD) begin
				gen <= 1'b1;
			end else if (gen && rnd == LAST_ROUND) begin
				gen <= 1'b0;
			end
		end
	end

	// window shift and word out
	always_ff @(posedge clk) begin
		if (shift_en) begin
			for (int i = 0; i < `SHA_BLOCK_WORDS - 1; i++) begin
				win[i] <= win[i+1];
			end
			win[`SHA_BLOCK_WORDS-1] <= w_in;
			w_word  <= w_in;
			w_round <= rnd;
		end
	end

endmodule

// File: design/round_engine.sv
`timescale 1ns/100ps

module round_engine (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  sha_pkg::sha_state_u state_init,
	input  logic                w_valid,
	input  sha_pkg::sha_word_t  w_word,
	input  sha_pkg::sha_round_t w_round,
	input  logic                w_last,
	output logic                done,
	output sha_pkg::sha_state_u state_final
);
	import sha_pkg::*;

	sha_state_u st;
	sha_state_u nxt;
	sha_word_t  s0;
	sha_word_t  s1;
	sha_word_t  ch;
	sha_word_t  maj;
	sha_word_t  t1;
	sha_word_t  t2;

	function automatic sha_word_t big_sigma0(input sha_word_t x);
		return sha_rotr(x, 2) ^ sha_rotr(x, 13) ^ sha_rotr(x, 22);
	endfunction

	function automatic sha_word_t big_sigma1(input sha_word_t x);
		return sha_rotr(x, 6) ^ sha_rotr(x, 11) ^ sha_rotr(x, 25);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// one compression round
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		s1  = big_sigma1(st.w.e);
		ch  = (st.w.e & st.w.f) ^ (~st.w.e & st.w.g);
		t1  = st.w.h + s1 + ch + sha_k(w_round) + w_word;
		s0  = big_sigma0(st.w.a);
		maj = (st.w.a & st.w.b) ^ (st.w.a & st.w.c) ^ (st.w.b & st.w.c);
		t2  = s0 + maj;

		// rotate the eight words down by one
		nxt.w.a = t1 + t2;
		nxt.w.b = st.w.a;
		nxt.w.c = st.w.b;
		nxt.w.d = st.w.c;
		nxt.w.e = st.w.d + t1;
		nxt.w.f = st.w.e;
		nxt.w.g = st.w.f;
		nxt.w.h = st.w.g;
	end

	// working variables
	always_ff @(posedge clk) begin
		if (start) begin
			st <= state_init;
		end else if (w_valid) begin
			st <= nxt;
		end
	end

	// last round applied in the same edge that latches the result
	assign done = w_valid & w_last;

	// result holds until the next run completes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_final.flat <= '0;
		end else if (done) begin
			state_final.flat <= nxt.flat;
		end
	end

endmodule

// File: design/sha256_core.sv
`timescale 1ns/100ps

module sha256_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                en,
	output logic                rdy,
	input  wb_pkg::wb_adr_t     base,
	input  sha_pkg::sha_state_u state_init,
	output sha_pkg::sha_state_u state_final,
	output logic                wb_cyc,
	output logic                wb_stb,
	output wb_pkg::wb_adr_t     wb_adr,
	input  wb_pkg::wb_dat_t     wb_rdata,
	input  logic                wb_ack
);
	import sha_pkg::*;

	logic       busy;
	logic       start;
	logic       done;
	logic       ld_valid;
	sha_word_t  ld_word;
	logic       w_valid;
	sha_word_t  w_word;
	sha_round_t w_round;
	logic       w_last;

	//////////////////////////////////////////////////////////////////////
	// start / ready control
	//////////////////////////////////////////////////////////////////////

	// en while a run is active is dropped
	assign start = en & ~busy;
	assign rdy   = ~busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
		end else if (done) begin
			busy <= 1'b0;
		end
	end

	// bus reads of the block
	msg_fetch u_fetch (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.base     (base),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_adr   (wb_adr),
		.wb_rdata (wb_rdata),
		.wb_ack   (wb_ack),
		.ld_valid (ld_valid),
		.ld_word  (ld_word)
	);

	// loaded words then expanded words, one per round
	msg_schedule u_sched (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.ld_valid (ld_valid),
		.ld_word  (ld_word),
		.w_valid  (w_valid),
		.w_word   (w_word),
		.w_round  (w_round),
		.w_last   (w_last)
	);

	round_engine u_round (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.state_init  (state_init),
		.w_valid     (w_valid),
		.w_word      (w_word),
		.w_round     (w_round),
		.w_last      (w_last),
		.done        (done),
		.state_final (state_final)
	);

endmodule

// File: design/sha_params.svh
`ifndef SHA_PARAMS_SVH
`define SHA_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// hash core sizes
//////////////////////////////////////////////////////////////////////

// bits per message, schedule and state word
`define SHA_WORD_W 32

// compression rounds per block
`define SHA_ROUNDS 64

// message words per 512-bit block
`define SHA_BLOCK_WORDS 16

// word address width of the memory bus
`define WB_ADR_W 8

`endif

// File: design/sha_pkg.sv
`include "sha_params.svh"

package sha_pkg;

	typedef logic [`SHA_WORD_W-1:0] sha_word_t;
	typedef logic [$clog2(`SHA_ROUNDS)-1:0] sha_round_t;

	// working variables, either as one vector or as a..h with a on top
	typedef union packed {
		logic [8*`SHA_WORD_W-1:0] flat;
		struct packed {
			sha_word_t a;
			sha_word_t b;
			sha_word_t c;
			sha_word_t d;
			sha_word_t e;
			sha_word_t f;
			sha_word_t g;
			sha_word_t h;
		} w;
	} sha_state_u;

	//////////////////////////////////////////////////////////////////////
	// round constants
	//////////////////////////////////////////////////////////////////////

	localparam sha_word_t SHA_K_TABLE [0:`SHA_ROUNDS-1] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// constant for one round index
	function automatic sha_word_t sha_k(input sha_round_t r);
		return SHA_K_TABLE[r];
	endfunction

	// rotate right, shared by the sigma functions
	function automatic sha_word_t sha_rotr(input sha_word_t x, input int unsigned n);
		return (x >> n) | (x << (`SHA_WORD_W - n));
	endfunction

endpackage

// File: design/wb_pkg.sv
`include "sha_params.svh"

package wb_pkg;

	//////////////////////////////////////////////////////////////////////
	// wishbone classic signal types
	//////////////////////////////////////////////////////////////////////

	// word address, wraps modulo the address space
	typedef logic [`WB_ADR_W-1:0] wb_adr_t;

	// read data, one message word per transfer
	typedef logic [`SHA_WORD_W-1:0] wb_dat_t;

endpackage

// File: sha256_core.f
+incdir+design
design/sha_pkg.sv
design/wb_pkg.sv
design/msg_fetch.sv
design/msg_schedule.sv
design/round_engine.sv
design/sha256_core.sv
test/sha256_assert.sv
test/sha256_tb.sv

// File: test/sha256_assert.sv
`timescale 1ns/100ps

module sha256_assert (
	input logic            clk,
	input logic            rst_n,
	input logic            rdy,
	input logic            wb_cyc,
	input logic            wb_stb,
	input logic            wb_ack,
	input wb_pkg::wb_adr_t wb_adr
);

	// strobe only inside a bus cycle
	a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb |-> wb_cyc)
		else $error("wb_stb high while wb_cyc is low");

	// classic cycle holds until acknowledged
	a_stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
		else $error("wb_stb or wb_adr changed before wb_ack");

	a_busy_on_bus: assert property (@(posedge clk) disable iff (!rst_n)
		wb_cyc |-> !rdy)
		else $error("rdy high during a bus cycle");

endmodule

bind sha256_core sha256_assert u_assert (
	.clk    (clk),
	.rst_n  (rst_n),
	.rdy    (rdy),
	.wb_cyc (wb_cyc),
	.wb_stb (wb_stb),
	.wb_ack (wb_ack),
	.wb_adr (wb_adr)
);

// File: test/sha256_tb.sv
`timescale 1ns/100ps
`include "sha_params.svh"

module sha256_tb;
	import sha_pkg::*;
	import wb_pkg::*;

	typedef struct {
		string   name;
		wb_adr_t base;
		bit      msg_rand;
		bit      init_rand;
		int      waits;
		bit      en_busy;
	} vec_t;

	localparam int NUM_VECS    = 7;
	localparam int MAX_WAIT    = 3;
	localparam int RESET_CYC   = 16;
	localparam int CYCLE_LIMIT = RESET_CYC + NUM_VECS * (16 * (MAX_WAIT + 3) + 100);

	localparam sha_state_u STD_IV = {32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};
	// abc working state after round 63 is the digest minus the IV
	localparam sha_state_u ABC_STATE = {32'h506e3058, 32'hd39a2165, 32'h04d24d6c, 32'hb85e2ce9,
		32'h5ef50f24, 32'hfb121210, 32'h948d25b6, 32'h961f4894};

	logic       clk = 1'b0;
	logic       rst_n;
	logic       en;
	logic       rdy;
	wb_adr_t    base;
	sha_state_u state_init;
	sha_state_u state_final;
	logic       wb_cyc;
	logic       wb_stb;
	wb_adr_t    wb_adr;
	wb_dat_t    wb_rdata = '0;
	logic       wb_ack = 1'b0;

	wb_dat_t mem [0:255];
	wb_adr_t seen_adr [$];
	int      wait_states = 0;
	int      wait_cnt = 0;
	int      cycles = 0;
	int      n_tests = 0;
	int      n_passed = 0;
	int      n_checks = 0;
	int      n_errors = 0;

	vec_t vecs [0:NUM_VECS-1] = '{
		'{"abc_iv",    8'h10, 1'b0, 1'b0, 0, 1'b0},
		'{"rand_ws0",  8'h40, 1'b1, 1'b1, 0, 1'b0},
		'{"rand_ws1",  8'h83, 1'b1, 1'b1, 1, 1'b0},
		'{"rand_ws3",  8'hc7, 1'b1, 1'b1, 3, 1'b0},
		'{"wrap_250",  8'hfa, 1'b1, 1'b1, 2, 1'b0},
		'{"en_busy",   8'h21, 1'b1, 1'b0, 1, 1'b1},
		'{"wrap_busy", 8'hf8, 1'b0, 1'b1, 3, 1'b1}
	};

	always #20 clk = ~clk;

	sha256_core dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.en          (en),
		.rdy         (rdy),
		.base        (base),
		.state_init  (state_init),
		.state_final (state_final),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_adr      (wb_adr),
		.wb_rdata    (wb_rdata),
		.wb_ack      (wb_ack)
	);

	//////////////////////////////////////////////////////////////////////
	// memory slave with wait states
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!rst_n) begin
			wb_ack   <= 1'b0;
			wait_cnt <= 0;
		end else if (wb_ack) begin
			// one ack per transfer
			wb_ack <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (wait_cnt < wait_states) begin
				wait_cnt <= wait_cnt + 1;
			end else begin
				wb_ack   <= 1'b1;
				wb_rdata <= mem[wb_adr];
				wait_cnt <= 0;
				seen_adr.push_back(wb_adr);
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout, the run was still going after %0d cycles", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic sha_word_t rotr(input sha_word_t x, input int n);
		logic [63:0] d;
		d = {x, x} >> n;
		return d[31:0];
	endfunction

	function automatic sha_word_t abc_word(input int i);
		if (i == 0)
			return 32'h61626380;
		if (i == 15)
			return 32'h00000018;
		return '0;
	endfunction

	function automatic sha_state_u random_state();
		sha_state_u s;
		for (int i = 0; i < 8; i++) begin
			s.flat[i*32 +: 32] = $urandom();
		end
		return s;
	endfunction

	// schedule expansion then 64 rounds without feed-forward
	task automatic model_state(input sha_word_t blk [0:15], input sha_state_u init,
			output sha_state_u res);
		sha_word_t w [0:`SHA_ROUNDS-1];
		sha_word_t a, b, c, d, e, f, g, h;
		sha_word_t t1, t2, s0, s1;
		for (int t = 0; t < `SHA_BLOCK_WORDS; t++) begin
			w[t] = blk[t];
		end
		for (int t = `SHA_BLOCK_WORDS; t < `SHA_ROUNDS; t++) begin
			s0   = rotr(w[t-15], 7) ^ rotr(w[t-15], 18) ^ (w[t-15] >> 3);
			s1   = rotr(w[t-2], 17) ^ rotr(w[t-2], 19) ^ (w[t-2] >> 10);
			w[t] = s1 + w[t-7] + s0 + w[t-16];
		end
		a = init.w.a;
		b = init.w.b;
		c = init.w.c;
		d = init.w.d;
		e = init.w.e;
		f = init.w.f;
		g = init.w.g;
		h = init.w.h;
		for (int t = 0; t < `SHA_ROUNDS; t++) begin
			t1 = h + (rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25)) + ((e & f) ^ (~e & g))
				+ sha_k(sha_round_t'(t)) + w[t];
			t2 = (rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
			h = g;
			g = f;
			f = e;
			e = d + t1;
			d = c;
			c = b;
			b = a;
			a = t1 + t2;
		end
		res.w = '{a, b, c, d, e, f, g, h};
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare and report
	//////////////////////////////////////////////////////////////////////

	task automatic check_state(input string what, input sha_state_u exp, input sha_state_u act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("** Error %s: expected %h, actual %h", what, exp.flat, act.flat);
		end
	endtask

	task automatic check_addr(input string what, input wb_adr_t exp, input wb_adr_t act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("** Error %s: expected %h, actual %h", what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("** Error %s: expected %b, actual %b", what, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		n_tests++;
		if (n_errors == errs_before) begin
			n_passed++;
			$display("%-10s ok", name);
		end else begin
			$display("%-10s failed with %0d errors", name, n_errors - errs_before);
		end
	endtask

	task automatic run_vector(input vec_t v);
		sha_word_t  blk [0:15];
		sha_state_u init;
		sha_state_u exp;
		wb_adr_t    adr;
		int         first;
		int         errs;
		errs = n_errors;
		for (int i = 0; i < 16; i++) begin
			blk[i] = v.msg_rand ? $urandom() : abc_word(i);
		end
		init = v.init_rand ? random_state() : STD_IV;
		model_state(blk, init, exp);
		// background words carry their own address
		for (int i = 0; i < 256; i++) begin
			mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] ^ 8'hc3};
		end
		for (int i = 0; i < 16; i++) begin
			adr      = v.base + wb_adr_t'(i);
			mem[adr] = blk[i];
		end
		wait_states = v.waits;
		first       = seen_adr.size();
		@(posedge clk);
		base       <= v.base;
		state_init <= init;
		en         <= 1'b1;
		@(posedge clk);
		en <= 1'b0;
		@(negedge clk);
		check_bit({v.name, " rdy after start"}, 1'b0, rdy);
		if (v.en_busy) begin
			// second request with other inputs is dropped
			repeat (4) @(posedge clk);
			base            <= v.base + 8'h40;
			state_init.flat <= ~init.flat;
			en              <= 1'b1;
			@(posedge clk);
			en <= 1'b0;
			@(negedge clk);
			check_bit({v.name, " rdy after en while busy"}, 1'b0, rdy);
		end
		while (rdy !== 1'b1) begin
			@(negedge clk);
		end
		check_state({v.name, " final state"}, exp, state_final);
		check_bit({v.name, " cyc after run"}, 1'b0, wb_cyc);
		if (seen_adr.size() - first != 16) begin
			n_errors++;
			$display("%s made %0d bus reads instead of 16", v.name, seen_adr.size() - first);
		end
		for (int i = 0; i < 16 && first + i < seen_adr.size(); i++) begin
			check_addr($sformatf("%s read %0d address", v.name, i),
				v.base + wb_adr_t'(i), seen_adr[first + i]);
		end
		report_test(v.name, errs);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		sha_word_t  blk [0:15];
		sha_state_u exp;
		int         errs;
		void'($urandom(32'h832b6c1f));
		rst_n      = 1'b0;
		en         = 1'b0;
		base       = '0;
		state_init = '0;
		repeat (RESET_CYC) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);

		errs = n_errors;
		check_bit("reset rdy", 1'b1, rdy);
		check_bit("reset wb_cyc", 1'b0, wb_cyc);
		check_bit("reset wb_stb", 1'b0, wb_stb);
		report_test("reset", errs);

		// model against the published abc example
		errs = n_errors;
		for (int i = 0; i < 16; i++) begin
			blk[i] = abc_word(i);
		end
		model_state(blk, STD_IV, exp);
		check_state("model_abc state", ABC_STATE, exp);
		report_test("model_abc", errs);

		for (int i = 0; i < NUM_VECS; i++) begin
			run_vector(vecs[i]);
		end
		repeat (2) @(posedge clk);

		$display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
			n_tests, n_passed, n_tests - n_passed, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
